// ==== hdl/mem_stage_pkg.sv ====
`default_nettype none

// ***************************************************************************
// Shared types and widths for the data-memory stage
// ***************************************************************************

package mem_stage_pkg;

    // Data path width
    localparam int XLEN = 32;

    // Register file index width
    localparam int REG_ADDR_W = 5;

    // Memory opcodes carried by each request
    // MEM_NONE gives a plain response, no bus cycle
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LH   = 4'd2,
        MEM_LW   = 4'd3,
        MEM_LBU  = 4'd4,
        MEM_LHU  = 4'd5,
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8
    } mem_op_e;

    // Access controller states
    // ST_IDLE  waiting for a request
    // ST_BUS   Wishbone cycle in progress, or exception decision
    // ST_RESP  response cycle, a new request may be taken here
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_BUS  = 2'd1,
        ST_RESP = 2'd2
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== hdl/store_align.sv ====
`timescale 1ns/1ps
`default_nettype none

// Store lane placement and byte selects
module store_align (
    input  mem_stage_pkg::mem_op_e           op_i,
    input  logic [1:0]                       addr_lo_i,
    input  logic [mem_stage_pkg::XLEN-1:0]   wdata_i,
    output logic [mem_stage_pkg::XLEN-1:0]   lane_data_o,
    output logic [3:0]                       sel_o,
    output logic                             misaligned_o
);

    import mem_stage_pkg::*;

    // ***********************************************************************
    // Lane placement
    // ***********************************************************************
    always_comb begin
        // Defaults, no lanes selected
        lane_data_o  = wdata_i;
        sel_o        = 4'b0000;
        misaligned_o = 1'b0;

        case (op_i)
            MEM_SB: begin
                // Byte copied onto every lane
                lane_data_o = {4{wdata_i[7:0]}};
                sel_o       = 4'b0001 << addr_lo_i;
            end
            MEM_SH: begin
                // Halfword copied onto both halves
                lane_data_o  = {2{wdata_i[15:0]}};
                sel_o        = addr_lo_i[1] ? 4'b1100 : 4'b0011;
                // Odd byte offset
                misaligned_o = addr_lo_i[0];
            end
            MEM_SW: begin
                sel_o        = 4'b1111;
                misaligned_o = |addr_lo_i;
            end
            MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU: begin
                // Reads fetch the whole word
                sel_o = 4'b1111;
            end
            default: begin
                sel_o = 4'b0000;
            end
        endcase
    end

    // ***********************************************************************
    // Checks
    // ***********************************************************************

    // Aligned store must enable at least one byte lane
    always_comb begin
        if ((op_i == MEM_SB || op_i == MEM_SH || op_i == MEM_SW) && !misaligned_o) begin
            assert (sel_o != 4'b0000)
                else $error("store_align: aligned store with empty byte select");
        end
    end

endmodule

`default_nettype wire

// ==== hdl/load_extract.sv ====
`timescale 1ns/1ps
`default_nettype none

// Load lane selection and extension
module load_extract (
    input  mem_stage_pkg::mem_op_e           op_i,
    input  logic [1:0]                       addr_lo_i,
    input  logic [mem_stage_pkg::XLEN-1:0]   rdata_i,
    output logic [mem_stage_pkg::XLEN-1:0]   ldata_o,
    output logic                             misaligned_o
);

    import mem_stage_pkg::*;

    // Lane picked by the address
    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    always_comb begin
        // Byte lane by offset
        byte_lane = rdata_i[8*addr_lo_i +: 8];
        // Upper or lower half
        half_lane = addr_lo_i[1] ? rdata_i[31:16] : rdata_i[15:0];
    end

    // ***********************************************************************
    // Extension
    // ***********************************************************************
    always_comb begin
        // Stores and MEM_NONE read back zero
        ldata_o      = '0;
        misaligned_o = 1'b0;

        case (op_i)
            MEM_LB: begin
                ldata_o = {{(XLEN-8){byte_lane[7]}}, byte_lane};
            end
            MEM_LBU: begin
                ldata_o = {{(XLEN-8){1'b0}}, byte_lane};
            end
            MEM_LH: begin
                ldata_o      = {{(XLEN-16){half_lane[15]}}, half_lane};
                misaligned_o = addr_lo_i[0];
            end
            MEM_LHU: begin
                ldata_o      = {{(XLEN-16){1'b0}}, half_lane};
                misaligned_o = addr_lo_i[0];
            end
            MEM_LW: begin
                // Word passes straight through
                ldata_o      = rdata_i;
                misaligned_o = |addr_lo_i;
            end
            default: begin
                ldata_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/mem_access_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

// Wishbone classic master, one request in flight
module mem_access_ctrl #(
    parameter int RAM_ADDR_W = 8
) (
    input  logic                                   Clk,
    input  logic                                   rst_i,
    // Request
    input  logic                                   req_valid_i,
    input  mem_stage_pkg::mem_op_e                 req_op_i,
    input  logic [mem_stage_pkg::XLEN-1:0]         req_addr_i,
    input  logic [mem_stage_pkg::XLEN-1:0]         req_wdata_i,
    input  logic [mem_stage_pkg::REG_ADDR_W-1:0]   req_rd_i,
    output logic                                   busy_o,
    // Response
    output logic                                   rsp_valid_o,
    output logic [mem_stage_pkg::XLEN-1:0]         rsp_data_o,
    output logic [mem_stage_pkg::REG_ADDR_W-1:0]   rsp_rd_o,
    output logic                                   rsp_exc_o,
    // Wishbone master
    output logic                                   wb_cyc_o,
    output logic                                   wb_stb_o,
    output logic                                   wb_we_o,
    output logic [RAM_ADDR_W-1:0]                  wb_adr_o,
    output logic [mem_stage_pkg::XLEN-1:0]         wb_dat_w_o,
    output logic [3:0]                             wb_sel_o,
    input  logic [mem_stage_pkg::XLEN-1:0]         wb_dat_r_i,
    input  logic                                   wb_ack_i,
    // Store and load helpers
    output mem_stage_pkg::mem_op_e                 op_o,
    output logic [1:0]                             addr_lo_o,
    output logic [mem_stage_pkg::XLEN-1:0]         wdata_o,
    input  logic [mem_stage_pkg::XLEN-1:0]         st_data_i,
    input  logic [3:0]                             st_sel_i,
    input  logic                                   st_misaligned_i,
    input  logic [mem_stage_pkg::XLEN-1:0]         ld_data_i,
    input  logic                                   ld_misaligned_i
);

    import mem_stage_pkg::*;

    ctrl_state_e            state_q;
    mem_op_e                op_q;
    logic [XLEN-1:0]        addr_q;
    logic [XLEN-1:0]        wdata_q;
    logic [REG_ADDR_W-1:0]  rd_q;
    logic [XLEN-1:0]        rsp_data_q;
    logic                   rsp_exc_q;
    logic                   accept;
    logic                   is_load;
    logic                   is_store;
    logic                   bad_access;
    logic                   skip_bus;
    logic                   bus_active;

    // ***********************************************************************
    // Decode of the held request
    // ***********************************************************************
    always_comb begin
        accept   = req_valid_i && !busy_o;
        is_load  = (op_q == MEM_LB) || (op_q == MEM_LH) || (op_q == MEM_LW) ||
                   (op_q == MEM_LBU) || (op_q == MEM_LHU);
        is_store = (op_q == MEM_SB) || (op_q == MEM_SH) || (op_q == MEM_SW);
        // Misaligned on either path, or beyond the RAM
        bad_access = (is_load || is_store) &&
                     (st_misaligned_i || ld_misaligned_i ||
                      (|addr_q[XLEN-1:RAM_ADDR_W+2]));
        // Exceptions and MEM_NONE answer without a bus cycle
        skip_bus   = bad_access || (op_q == MEM_NONE);
        bus_active = (state_q == ST_BUS) && !skip_bus;
    end

    // Request registers, loaded on accept
    always_ff @(posedge Clk) begin
        if (accept) begin
            op_q    <= req_op_i;
            addr_q  <= req_addr_i;
            wdata_q <= req_wdata_i;
            rd_q    <= req_rd_i;
        end
    end

    // ***********************************************************************
    // State machine and response
    // ***********************************************************************
    always_ff @(posedge Clk) begin
        if (rst_i) begin
            state_q   <= ST_IDLE;
            rsp_exc_q <= 1'b0;
        end else begin
            case (state_q)
                ST_BUS: begin
                    // Done on exception or on ack
                    if (skip_bus || wb_ack_i) begin
                        state_q   <= ST_RESP;
                        rsp_exc_q <= bad_access;
                    end
                end
                default: begin
                    // Idle and response cycles both take requests
                    state_q <= accept ? ST_BUS : ST_IDLE;
                end
            endcase
        end
    end

    // Load data captured with ack, zero otherwise
    always_ff @(posedge Clk) begin
        if (state_q == ST_BUS && (skip_bus || wb_ack_i)) begin
            rsp_data_q <= (is_load && !skip_bus) ? ld_data_i : '0;
        end
    end

    assign busy_o      = (state_q == ST_BUS);
    assign rsp_valid_o = (state_q == ST_RESP);
    assign rsp_data_o  = rsp_data_q;
    assign rsp_rd_o    = rd_q;
    assign rsp_exc_o   = rsp_exc_q;

    // Bus signals held steady by the request registers
    assign wb_cyc_o   = bus_active;
    assign wb_stb_o   = bus_active;
    assign wb_we_o    = bus_active && is_store;
    assign wb_adr_o   = addr_q[RAM_ADDR_W+1:2];
    assign wb_dat_w_o = st_data_i;
    assign wb_sel_o   = st_sel_i;

    // Helper paths see the held request
    assign op_o      = op_q;
    assign addr_lo_o = addr_q[1:0];
    assign wdata_o   = wdata_q;

    // ***********************************************************************
    // Checks
    // ***********************************************************************
    assert property (@(posedge Clk) disable iff (rst_i) wb_stb_o |-> wb_cyc_o);

    // Classic cycle holds until ack
    assert property (@(posedge Clk) disable iff (rst_i)
        wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o) &&
                                   $stable(wb_dat_w_o) && $stable(wb_sel_o));

    assert property (@(posedge Clk) disable iff (rst_i) rsp_valid_o |=> !rsp_valid_o);

    // Word loads come back from the RAM untouched
    assert property (@(posedge Clk) disable iff (rst_i)
        wb_ack_i && op_q == MEM_LW |-> ld_data_i == wb_dat_r_i);

endmodule

`default_nettype wire

// ==== hdl/wb_data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

// Word-wide data RAM on a Wishbone classic slave port
module wb_data_ram #(
    parameter int RAM_ADDR_W = 8
) (
    input  logic                               Clk,
    input  logic                               rst_i,
    input  logic                               wb_cyc_i,
    input  logic                               wb_stb_i,
    input  logic                               wb_we_i,
    input  logic [RAM_ADDR_W-1:0]              wb_adr_i,
    input  logic [mem_stage_pkg::XLEN-1:0]     wb_dat_i,
    input  logic [3:0]                         wb_sel_i,
    output logic [mem_stage_pkg::XLEN-1:0]     wb_dat_o,
    output logic                               wb_ack_o
);

    import mem_stage_pkg::*;

    // Single-port word array
    logic [XLEN-1:0] mem [2**RAM_ADDR_W];
    logic            access;

    // Contents start at zero
    initial begin
        for (int i = 0; i < 2**RAM_ADDR_W; i++) begin
            mem[i] = '0;
        end
    end

    // New strobe not yet answered
    assign access = wb_cyc_i && wb_stb_i && !wb_ack_o;

    // One-cycle ack per strobe
    always_ff @(posedge Clk) begin
        if (rst_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= access;
        end
    end

    // Byte-lane writes and registered read, same edge as ack
    always_ff @(posedge Clk) begin
        if (access) begin
            if (wb_we_i) begin
                for (int b = 0; b < 4; b++) begin
                    if (wb_sel_i[b]) begin
                        mem[wb_adr_i][8*b +: 8] <= wb_dat_i[8*b +: 8];
                    end
                end
            end
            wb_dat_o <= mem[wb_adr_i];
        end
    end

    // Master keeps cyc until ack
    assert property (@(posedge Clk) disable iff (rst_i) wb_ack_o |-> wb_cyc_i);

endmodule

`default_nettype wire

// ==== hdl/mem_stage_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// Data-memory stage: store and load paths, controller, RAM
module mem_stage_top #(
    parameter int RAM_ADDR_W = 8
) (
    input  logic                                   Clk,
    input  logic                                   rst_i,
    input  logic                                   req_valid_i,
    input  mem_stage_pkg::mem_op_e                 req_op_i,
    input  logic [mem_stage_pkg::XLEN-1:0]         req_addr_i,
    input  logic [mem_stage_pkg::XLEN-1:0]         req_wdata_i,
    input  logic [mem_stage_pkg::REG_ADDR_W-1:0]   req_rd_i,
    output logic                                   busy_o,
    output logic                                   rsp_valid_o,
    output logic [mem_stage_pkg::XLEN-1:0]         rsp_data_o,
    output logic [mem_stage_pkg::REG_ADDR_W-1:0]   rsp_rd_o,
    output logic                                   rsp_exc_o
);

    import mem_stage_pkg::*;

    // Held request toward the helper paths
    mem_op_e          op;
    logic [1:0]       addr_lo;
    logic [XLEN-1:0]  wdata;
    // Helper results
    logic [XLEN-1:0]  st_data;
    logic [3:0]       st_sel;
    logic             st_misaligned;
    logic [XLEN-1:0]  ld_data;
    logic             ld_misaligned;
    // Wishbone
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [RAM_ADDR_W-1:0]  wb_adr;
    logic [XLEN-1:0]        wb_dat_w;
    logic [3:0]             wb_sel;
    logic [XLEN-1:0]        wb_dat_r;
    logic                   wb_ack;

    store_align u_store_align (
        .op_i         (op),
        .addr_lo_i    (addr_lo),
        .wdata_i      (wdata),
        .lane_data_o  (st_data),
        .sel_o        (st_sel),
        .misaligned_o (st_misaligned)
    );

    load_extract u_load_extract (
        .op_i         (op),
        .addr_lo_i    (addr_lo),
        .rdata_i      (wb_dat_r),
        .ldata_o      (ld_data),
        .misaligned_o (ld_misaligned)
    );

    mem_access_ctrl #(
        .RAM_ADDR_W (RAM_ADDR_W)
    ) u_ctrl (
        .Clk             (Clk),
        .rst_i           (rst_i),
        .req_valid_i     (req_valid_i),
        .req_op_i        (req_op_i),
        .req_addr_i      (req_addr_i),
        .req_wdata_i     (req_wdata_i),
        .req_rd_i        (req_rd_i),
        .busy_o          (busy_o),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_data_o      (rsp_data_o),
        .rsp_rd_o        (rsp_rd_o),
        .rsp_exc_o       (rsp_exc_o),
        .wb_cyc_o        (wb_cyc),
        .wb_stb_o        (wb_stb),
        .wb_we_o         (wb_we),
        .wb_adr_o        (wb_adr),
        .wb_dat_w_o      (wb_dat_w),
        .wb_sel_o        (wb_sel),
        .wb_dat_r_i      (wb_dat_r),
        .wb_ack_i        (wb_ack),
        .op_o            (op),
        .addr_lo_o       (addr_lo),
        .wdata_o         (wdata),
        .st_data_i       (st_data),
        .st_sel_i        (st_sel),
        .st_misaligned_i (st_misaligned),
        .ld_data_i       (ld_data),
        .ld_misaligned_i (ld_misaligned)
    );

    wb_data_ram #(
        .RAM_ADDR_W (RAM_ADDR_W)
    ) u_ram (
        .Clk      (Clk),
        .rst_i    (rst_i),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_sel_i (wb_sel),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack)
    );

endmodule

`default_nettype wire

// ==== dv/mem_stage_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

// Watches the request and response ports and scores every response
module mem_stage_checker #(
    parameter int RAM_ADDR_W = 8
) (
    input  logic                                   Clk,
    input  logic                                   rst_i,
    input  logic                                   req_valid_i,
    input  mem_stage_pkg::mem_op_e                 req_op_i,
    input  logic [mem_stage_pkg::XLEN-1:0]         req_addr_i,
    input  logic [mem_stage_pkg::XLEN-1:0]         req_wdata_i,
    input  logic [mem_stage_pkg::REG_ADDR_W-1:0]   req_rd_i,
    input  logic                                   busy_i,
    input  logic                                   exp_exc_i,
    input  logic                                   rsp_valid_i,
    input  logic [mem_stage_pkg::XLEN-1:0]         rsp_data_i,
    input  logic [mem_stage_pkg::REG_ADDR_W-1:0]   rsp_rd_i,
    input  logic                                   rsp_exc_i,
    output int                                     taken_o,
    output int                                     pass_o,
    output int                                     fail_o,
    output int                                     pending_o
);

    import mem_stage_pkg::*;

    // Byte-wide shadow of the RAM
    logic [7:0] shadow [4*2**RAM_ADDR_W];

    // Outstanding responses with the oldest first
    mem_op_e                op_q   [$];
    logic [XLEN-1:0]        addr_q [$];
    logic [XLEN-1:0]        data_q [$];
    logic [REG_ADDR_W-1:0]  rd_q   [$];
    logic                   exc_q  [$];
    int                     due_q  [$];

    // Rising edges seen so far
    int   cycle;
    logic rst_q;

    initial begin
        shadow    = '{default: '0};
        cycle     = 0;
        rst_q     = 1'b0;
        taken_o   = 0;
        pass_o    = 0;
        fail_o    = 0;
        pending_o = 0;
    end

    // ***********************************************************************
    // Reference model
    // ***********************************************************************

    // Applies one request to the shadow and returns the expected load result
    task automatic predict(input mem_op_e op, input logic [XLEN-1:0] addr,
                           input logic [XLEN-1:0] wdata, output logic [XLEN-1:0] data);
        logic [RAM_ADDR_W-1:0] wa;
        logic [1:0]            lo;
        logic [7:0]            b;
        logic [15:0]           h;
        logic [XLEN-1:0]       w;
        wa = addr[RAM_ADDR_W+1:2];
        lo = addr[1:0];
        // Rebuild the word with byte 0 lowest
        for (int k = 0; k < 4; k++) begin
            w[8*k +: 8] = shadow[{wa, k[1:0]}];
        end
        b    = w[8*lo +: 8];
        h    = lo[1] ? w[31:16] : w[15:0];
        data = '0;
        case (op)
            MEM_LB:  data = {{24{b[7]}}, b};
            MEM_LBU: data = {24'd0, b};
            MEM_LH:  data = {{16{h[15]}}, h};
            MEM_LHU: data = {16'd0, h};
            MEM_LW:  data = w;
            MEM_SB:  shadow[{wa, lo}] = wdata[7:0];
            MEM_SH: begin
                shadow[{wa, lo[1], 1'b0}] = wdata[7:0];
                shadow[{wa, lo[1], 1'b1}] = wdata[15:8];
            end
            MEM_SW: begin
                for (int k = 0; k < 4; k++) begin
                    shadow[{wa, k[1:0]}] = wdata[8*k +: 8];
                end
            end
            default: data = '0;
        endcase
    endtask

    // Drops the oldest outstanding entry
    task automatic retire_oldest();
        void'(op_q.pop_front());
        void'(addr_q.pop_front());
        void'(data_q.pop_front());
        void'(rd_q.pop_front());
        void'(exc_q.pop_front());
        void'(due_q.pop_front());
    endtask

    // ***********************************************************************
    // Scoring
    // ***********************************************************************
    always @(posedge Clk) begin
        logic [XLEN-1:0] exp_data;
        logic            ok;
        mem_op_e         op;
        cycle++;

        // Unit idle right after reset
        if (rst_q && !rst_i) begin
            if (busy_i || rsp_valid_i) begin
                $display("ERR %0t: unit not idle after reset (busy=%0b rsp_valid=%0b)",
                         $time, busy_i, rsp_valid_i);
                fail_o++;
            end else begin
                $display("ok  %0t: idle after reset", $time);
                pass_o++;
            end
        end
        rst_q = rst_i;

        // Response against the oldest prediction
        if (!rst_i && rsp_valid_i) begin
            if (due_q.size() == 0) begin
                $display("Extra response at %0t with nothing outstanding (rd=%0d)",
                         $time, rsp_rd_i);
                fail_o++;
            end else begin
                op = op_q[0];
                ok = (rsp_data_i === data_q[0]) && (rsp_rd_i === rd_q[0]) &&
                     (rsp_exc_i === exc_q[0]) && (due_q[0] == cycle);
                if (ok) begin
                    $display("ok  %0t: %s addr=%h rd=%0d data=%h exc=%0b", $time,
                             op.name(), addr_q[0], rsp_rd_i, rsp_data_i, rsp_exc_i);
                    pass_o++;
                end else begin
                    $write("ERR %0t: %s addr=%h got data=%h rd=%0d exc=%0b cycle=%0d,",
                           $time, op.name(), addr_q[0], rsp_data_i, rsp_rd_i, rsp_exc_i,
                           cycle);
                    $display(" expected data=%h rd=%0d exc=%0b cycle=%0d",
                             data_q[0], rd_q[0], exc_q[0], due_q[0]);
                    fail_o++;
                end
                retire_oldest();
            end
        end

        // Overdue
        if (due_q.size() != 0 && due_q[0] < cycle) begin
            op = op_q[0];
            $display("Missing response to %s at address %h, due at cycle %0d",
                     op.name(), addr_q[0], due_q[0]);
            fail_o++;
            retire_oldest();
        end

        // Request taken at this edge
        if (!rst_i && req_valid_i && !busy_i) begin
            if (exp_exc_i) begin
                exp_data = '0;
            end else begin
                predict(req_op_i, req_addr_i, req_wdata_i, exp_data);
            end
            op_q.push_back(req_op_i);
            addr_q.push_back(req_addr_i);
            data_q.push_back(exp_data);
            rd_q.push_back(req_rd_i);
            exc_q.push_back(exp_exc_i);
            // No bus cycle answers one edge sooner
            due_q.push_back(cycle + ((exp_exc_i || req_op_i == MEM_NONE) ? 2 : 3));
            taken_o++;
        end
        pending_o = due_q.size();
    end

endmodule

`default_nettype wire

// ==== dv/tb_mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage;

    import mem_stage_pkg::*;

    localparam int RAM_ADDR_W   = 8;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;

    // Entry flags
    localparam logic [2:0] F_NONE = 3'b000;
    localparam logic [2:0] F_RND  = 3'b001;
    localparam logic [2:0] F_EXC  = 3'b010;
    localparam logic [2:0] F_HOLD = 3'b100;

    logic                   Clk;
    logic                   rst_i;
    logic                   req_valid_i;
    mem_op_e                req_op_i;
    logic [XLEN-1:0]        req_addr_i;
    logic [XLEN-1:0]        req_wdata_i;
    logic [REG_ADDR_W-1:0]  req_rd_i;
    logic                   exp_exc;
    logic                   busy_o;
    logic                   rsp_valid_o;
    logic [XLEN-1:0]        rsp_data_o;
    logic [REG_ADDR_W-1:0]  rsp_rd_o;
    logic                   rsp_exc_o;
    int                     taken;
    int                     passes;
    int                     fails;
    int                     pending;

    // Stimulus table, one column per queue
    mem_op_e                tbl_op   [$];
    logic [XLEN-1:0]        tbl_addr [$];
    logic [REG_ADDR_W-1:0]  tbl_rd   [$];
    logic [XLEN-1:0]        tbl_data [$];
    logic                   tbl_rnd  [$];
    logic                   tbl_exc  [$];
    logic                   tbl_hold [$];

    logic [31:0] lfsr;
    int          watchdog_ns;
    logic        table_ready;

    always #(CLK_PERIOD/2) Clk = ~Clk;

    mem_stage_top #(
        .RAM_ADDR_W (RAM_ADDR_W)
    ) DUT (
        .Clk         (Clk),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_op_i    (req_op_i),
        .req_addr_i  (req_addr_i),
        .req_wdata_i (req_wdata_i),
        .req_rd_i    (req_rd_i),
        .busy_o      (busy_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_data_o  (rsp_data_o),
        .rsp_rd_o    (rsp_rd_o),
        .rsp_exc_o   (rsp_exc_o)
    );

    mem_stage_checker #(
        .RAM_ADDR_W (RAM_ADDR_W)
    ) u_checker (
        .Clk         (Clk),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_op_i    (req_op_i),
        .req_addr_i  (req_addr_i),
        .req_wdata_i (req_wdata_i),
        .req_rd_i    (req_rd_i),
        .busy_i      (busy_o),
        .exp_exc_i   (exp_exc),
        .rsp_valid_i (rsp_valid_o),
        .rsp_data_i  (rsp_data_o),
        .rsp_rd_i    (rsp_rd_o),
        .rsp_exc_i   (rsp_exc_o),
        .taken_o     (taken),
        .pass_o      (passes),
        .fail_o      (fails),
        .pending_o   (pending)
    );

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit drawn
    function automatic logic lfsr_bit();
        logic out;
        out  = lfsr[0];
        lfsr = {1'b0, lfsr[31:1]} ^ (out ? 32'h8020_0003 : 32'h0000_0000);
        return out;
    endfunction

    function automatic logic [XLEN-1:0] random_word();
        logic [XLEN-1:0] w;
        for (int i = 0; i < XLEN; i++) begin
            w[i] = lfsr_bit();
        end
        return w;
    endfunction

    task automatic add_entry(input mem_op_e op, input logic [XLEN-1:0] addr,
                             input logic [REG_ADDR_W-1:0] rd, input logic [XLEN-1:0] data,
                             input logic [2:0] flags);
        tbl_op.push_back(op);
        tbl_addr.push_back(addr);
        tbl_rd.push_back(rd);
        tbl_data.push_back(data);
        tbl_rnd.push_back(flags[0]);
        tbl_exc.push_back(flags[1]);
        tbl_hold.push_back(flags[2]);
    endtask

    // ***********************************************************************
    // Stimulus table
    // ***********************************************************************
    task automatic build_table();
        // Word store and reload
        add_entry(MEM_SW,   32'h0000_0010, 5'd1,  32'hDEAD_BEEF, F_NONE);
        add_entry(MEM_LW,   32'h0000_0010, 5'd2,  32'h0,         F_HOLD);
        add_entry(MEM_SW,   32'h0000_0014, 5'd3,  32'h0,         F_RND);
        add_entry(MEM_LW,   32'h0000_0014, 5'd4,  32'h0,         F_NONE);
        // Byte lanes, untouched bytes keep the old word
        add_entry(MEM_SW,   32'h0000_0020, 5'd5,  32'hCAFE_F00D, F_NONE);
        add_entry(MEM_SB,   32'h0000_0020, 5'd6,  32'h0,         F_RND | F_HOLD);
        add_entry(MEM_SB,   32'h0000_0023, 5'd7,  32'h0,         F_RND);
        add_entry(MEM_LW,   32'h0000_0020, 5'd8,  32'h0,         F_NONE);
        add_entry(MEM_SB,   32'h0000_0021, 5'd9,  32'h0000_005A, F_NONE);
        add_entry(MEM_SB,   32'h0000_0022, 5'd10, 32'hFFFF_FFA5, F_HOLD);
        add_entry(MEM_LW,   32'h0000_0020, 5'd11, 32'h0,         F_NONE);
        // Byte extension on every offset
        add_entry(MEM_SW,   32'h0000_0030, 5'd12, 32'h80FF_7F01, F_NONE);
        add_entry(MEM_LB,   32'h0000_0030, 5'd13, 32'h0,         F_NONE);
        add_entry(MEM_LB,   32'h0000_0031, 5'd14, 32'h0,         F_HOLD);
        add_entry(MEM_LB,   32'h0000_0032, 5'd15, 32'h0,         F_NONE);
        add_entry(MEM_LB,   32'h0000_0033, 5'd16, 32'h0,         F_NONE);
        add_entry(MEM_LBU,  32'h0000_0030, 5'd17, 32'h0,         F_NONE);
        add_entry(MEM_LBU,  32'h0000_0031, 5'd18, 32'h0,         F_NONE);
        add_entry(MEM_LBU,  32'h0000_0032, 5'd19, 32'h0,         F_HOLD);
        add_entry(MEM_LBU,  32'h0000_0033, 5'd20, 32'h0,         F_NONE);
        // Halfword extension, negative halves in the second word
        add_entry(MEM_SW,   32'h0000_0034, 5'd21, 32'hF00D_8001, F_NONE);
        add_entry(MEM_LH,   32'h0000_0030, 5'd22, 32'h0,         F_NONE);
        add_entry(MEM_LH,   32'h0000_0032, 5'd23, 32'h0,         F_NONE);
        add_entry(MEM_LHU,  32'h0000_0032, 5'd24, 32'h0,         F_HOLD);
        add_entry(MEM_LH,   32'h0000_0034, 5'd25, 32'h0,         F_NONE);
        add_entry(MEM_LHU,  32'h0000_0034, 5'd26, 32'h0,         F_NONE);
        add_entry(MEM_LH,   32'h0000_0036, 5'd27, 32'h0,         F_NONE);
        add_entry(MEM_LHU,  32'h0000_0036, 5'd28, 32'h0,         F_NONE);
        // Misaligned, memory must stay as it was
        add_entry(MEM_SH,   32'h0000_0031, 5'd29, 32'h0000_FFFF, F_EXC);
        add_entry(MEM_LH,   32'h0000_0033, 5'd30, 32'h0,         F_EXC);
        add_entry(MEM_LHU,  32'h0000_0035, 5'd31, 32'h0,         F_EXC | F_HOLD);
        add_entry(MEM_SW,   32'h0000_0032, 5'd1,  32'hFFFF_FFFF, F_EXC);
        add_entry(MEM_LW,   32'h0000_0031, 5'd2,  32'h0,         F_EXC | F_HOLD);
        add_entry(MEM_SW,   32'h0000_0013, 5'd3,  32'h0,         F_EXC);
        add_entry(MEM_LW,   32'h0000_0030, 5'd4,  32'h0,         F_NONE);
        add_entry(MEM_LW,   32'h0000_0010, 5'd5,  32'h0,         F_NONE);
        // Beyond the 256-word RAM
        add_entry(MEM_LW,   32'h0000_0400, 5'd6,  32'h0,         F_EXC);
        add_entry(MEM_SW,   32'h0000_1000, 5'd7,  32'h1234_5678, F_EXC | F_HOLD);
        add_entry(MEM_SB,   32'h8000_0000, 5'd8,  32'h0000_0077, F_EXC);
        add_entry(MEM_NONE, 32'h0000_0000, 5'd9,  32'h0,         F_HOLD);
        // Halfword stores on both halves
        add_entry(MEM_SH,   32'h0000_0040, 5'd10, 32'h0,         F_RND);
        add_entry(MEM_SH,   32'h0000_0042, 5'd11, 32'h0,         F_RND | F_HOLD);
        add_entry(MEM_LW,   32'h0000_0040, 5'd12, 32'h0,         F_NONE);
    endtask

    // ***********************************************************************
    // Request loop
    // ***********************************************************************
    initial begin
        Clk         = 1'b0;
        rst_i       = 1'b1;
        req_valid_i = 1'b0;
        req_op_i    = MEM_NONE;
        req_addr_i  = '0;
        req_wdata_i = '0;
        req_rd_i    = '0;
        exp_exc     = 1'b0;
        lfsr        = 32'd93127;
        table_ready = 1'b0;
        build_table();
        // Four cycles per entry at most, plus reset and slack
        watchdog_ns = tbl_op.size() * 4 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD + 1000;
        table_ready = 1'b1;

        repeat (RESET_CYCLES) @(negedge Clk);
        rst_i = 1'b0;

        for (int i = 0; i < tbl_op.size(); i++) begin
            // Held entries go out while the unit is still busy
            if (!tbl_hold[i]) begin
                req_valid_i = 1'b0;
                while (busy_o) @(negedge Clk);
            end
            req_op_i    = tbl_op[i];
            req_addr_i  = tbl_addr[i];
            req_rd_i    = tbl_rd[i];
            req_wdata_i = tbl_rnd[i] ? random_word() : tbl_data[i];
            exp_exc     = tbl_exc[i];
            req_valid_i = 1'b1;
            // Taken at the first rising edge with busy low
            while (busy_o) @(negedge Clk);
            @(negedge Clk);
        end
        req_valid_i = 1'b0;

        // Let outstanding responses drain, then watch for strays
        while (pending != 0) @(negedge Clk);
        repeat (4) @(negedge Clk);

        if (taken != tbl_op.size()) begin
            $display("Request count mismatch: %0d entries issued but %0d taken",
                     tbl_op.size(), taken);
        end
        $display("Summary: %0d passed, %0d failed, %0d of %0d requests taken",
                 passes, fails, taken, tbl_op.size());
        if (fails == 0 && taken == tbl_op.size()) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (table_ready === 1'b1);
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns, the request loop never finished",
                 watchdog_ns);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
hdl/mem_stage_pkg.sv
hdl/store_align.sv
hdl/load_extract.sv
hdl/mem_access_ctrl.sv
hdl/wb_data_ram.sv
hdl/mem_stage_top.sv
dv/mem_stage_checker.sv
dv/tb_mem_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the data-memory stage testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sim.f --top-module tb_mem_stage -o sim_mem_stage

./obj_dir/sim_mem_stage | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
